// File: hw/ciPkg.sv
package ciPkg;

  // operand and result word of the custom-instruction port
  typedef logic [31:0] ciWord_t;

  // custom-instruction number as seen on ciN
  typedef logic [7:0] ciId_t;

  // every unit answers with one of these, the top ORs them together
  typedef struct packed {
    logic    done;
    ciWord_t result;
  } ciResponse_t;

  // ############################
  // instruction ids
  localparam ciId_t swapByteId = 8'd1;
  localparam ciId_t delayId = 8'd6;
  localparam ciId_t profileId = 8'd8;

  // ############################
  // timing

  // 74.25 MHz system clock, fraction dropped
  localparam int unsigned cpuCyclesPerMicrosecond = 74;

  // cycles the CPU stays in reset after PLL lock
  localparam int unsigned resetHoldCycles = 16;

endpackage

// File: hw/profilePkg.sv
package profilePkg;

  localparam int unsigned nrOfCounters = 4;

  // one bit per counter
  typedef logic [nrOfCounters - 1:0] counterMask_t;

  // counter index taken from operand A
  typedef logic [$clog2(nrOfCounters) - 1:0] counterSel_t;

  typedef ciPkg::ciWord_t counterArray_t [nrOfCounters];

  // low bit of each 4-bit command mask in operand B
  localparam int unsigned enableField = 0;
  localparam int unsigned disableField = 4;
  localparam int unsigned clearField = 8;

endpackage

// File: hw/ciBus.sv
`timescale 1ns/1ps

// instruction request from the CPU, fanned out to every unit
interface ciBus;
  import ciPkg::*;

  // one-cycle pulse, the operands are valid in that cycle only
  logic    start;
  ciId_t   n;
  ciWord_t dataA;
  ciWord_t dataB;

  modport cpu (
    output start,
    output n,
    output dataA,
    output dataB
  );

  modport unit (
    input start,
    input n,
    input dataA,
    input dataB
  );

endinterface

// File: hw/resetSequencer.sv
`timescale 1ns/1ps

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic cpuReset
);
  import ciPkg::*;

  typedef logic [$clog2(resetHoldCycles + 1) - 1:0] holdCount_t;

  holdCount_t holdCount;
  logic       holdDone;

  assign holdDone = (holdCount == holdCount_t'(resetHoldCycles));

  // saturates once the hold time has passed
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      holdCount <= '0;
    end else if (!holdDone) begin
      holdCount <= holdCount + holdCount_t'(1);
    end
  end

  assign cpuReset = !holdDone;

  // once released the CPU stays out of reset until the PLL drops lock
  releaseIsFinal : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    !cpuReset |=> !cpuReset
  );

endmodule

// File: hw/swapByteUnit.sv
`timescale 1ns/1ps

module swapByteUnit (
  ciBus.unit                 ci,
  output ciPkg::ciResponse_t response
);
  import ciPkg::*;

  logic    hit;
  ciWord_t swapped;

  assign hit = ci.start && (ci.n == swapByteId);

  // dataB bit 0 picks the mode
  always_comb begin
    if (ci.dataB[0]) begin
      // swap the bytes inside each halfword
      swapped = {ci.dataA[23:16], ci.dataA[31:24], ci.dataA[7:0], ci.dataA[15:8]};
    end else begin
      // full word byte reversal
      swapped = {ci.dataA[7:0], ci.dataA[15:8], ci.dataA[23:16], ci.dataA[31:24]};
    end
  end

  // answers in the start cycle
  assign response.done = hit;
  assign response.result = hit ? swapped : '0;

endmodule

// File: hw/delayUnit.sv
`timescale 1ns/1ps

module delayUnit #(
  parameter int unsigned cyclesPerMicrosecond = ciPkg::cpuCyclesPerMicrosecond
) (
  input  logic               s_systemClock,
  input  logic               s_pllLocked,
  ciBus.unit                 ci,
  output ciPkg::ciResponse_t response
);
  import ciPkg::*;

  typedef logic [$clog2(cyclesPerMicrosecond + 1) - 1:0] prescale_t;

  logic      startDelay;
  logic      busy;
  logic      doneReg;
  logic      lastCycle;
  ciWord_t   microseconds;
  prescale_t prescaler;

  assign startDelay = ci.start && (ci.n == delayId);

  // final edge of the last microsecond
  assign lastCycle = (prescaler == '0) && (microseconds == ciWord_t'(1));

  // ############################
  // countdown
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      busy <= 1'b0;
      doneReg <= 1'b0;
      microseconds <= '0;
      prescaler <= '0;
    end else begin
      doneReg <= 1'b0;
      if (startDelay) begin
        microseconds <= ci.dataA;
        prescaler <= prescale_t'(cyclesPerMicrosecond - 1);
        // a zero delay answers on the next cycle
        busy <= (ci.dataA != '0);
        doneReg <= (ci.dataA == '0);
      end else if (busy) begin
        if (lastCycle) begin
          busy <= 1'b0;
          doneReg <= 1'b1;
        end else if (prescaler == '0) begin
          prescaler <= prescale_t'(cyclesPerMicrosecond - 1);
          microseconds <= microseconds - ciWord_t'(1);
        end else begin
          prescaler <= prescaler - prescale_t'(1);
        end
      end
    end
  end

  assign response.done = doneReg;
  assign response.result = '0;

  // the CPU blocks until done, so no second delay may start meanwhile
  noStartWhileBusy : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    (busy || doneReg) |-> !startDelay
  );

endmodule

// File: hw/profileControl.sv
`timescale 1ns/1ps

module profileControl (
  input  logic                     s_systemClock,
  input  logic                     s_pllLocked,
  ciBus.unit                       ci,
  output profilePkg::counterMask_t enableMask,
  output profilePkg::counterMask_t clearMask,
  input  profilePkg::counterArray_t counters,
  output ciPkg::ciResponse_t       response
);
  import ciPkg::*;
  import profilePkg::*;

  logic         hit;
  counterSel_t  sel;
  counterMask_t enableReg;
  counterMask_t enableCmd;
  counterMask_t disableCmd;
  counterMask_t clearCmd;

  assign hit = ci.start && (ci.n == profileId);
  assign sel = ci.dataA[$bits(counterSel_t) - 1:0];

  // ############################
  // command fields of operand B
  assign enableCmd = ci.dataB[enableField +: nrOfCounters];
  assign disableCmd = ci.dataB[disableField +: nrOfCounters];
  assign clearCmd = ci.dataB[clearField +: nrOfCounters];

  // disable wins over enable for the same counter
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      enableReg <= '0;
    end else if (hit) begin
      enableReg <= (enableReg | enableCmd) & ~disableCmd;
    end
  end

  assign enableMask = enableReg;

  // clear lasts for the start cycle only
  assign clearMask = hit ? clearCmd : '0;

  // read value is the one held before the command takes effect
  assign response.done = hit;
  assign response.result = hit ? counters[sel] : '0;

endmodule

// File: hw/profileCounters.sv
`timescale 1ns/1ps

module profileCounters (
  input  logic                      s_systemClock,
  input  logic                      s_pllLocked,
  input  logic                      cpuReset,
  input  logic                      stall,
  input  logic                      busIdle,
  input  profilePkg::counterMask_t  enableMask,
  input  profilePkg::counterMask_t  clearMask,
  output profilePkg::counterArray_t counters
);
  import ciPkg::*;
  import profilePkg::*;

  counterMask_t events;

  // event per counter: cycles, stall, bus idle, stall with idle bus
  assign events = {stall & busIdle, busIdle, stall, 1'b1};

  // ############################
  // counters
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      for (int i = 0; i < nrOfCounters; i++) begin
        counters[i] <= '0;
      end
    end else begin
      for (int i = 0; i < nrOfCounters; i++) begin
        if (cpuReset || clearMask[i]) begin
          counters[i] <= '0;
        end else if (enableMask[i] && events[i]) begin
          // wraps at the top
          counters[i] <= counters[i] + ciWord_t'(1);
        end
      end
    end
  end

endmodule

// File: hw/or1420CiSubsystem.sv
`timescale 1ns/1ps

module or1420CiSubsystem (
  input  logic           s_systemClock,
  input  logic           s_pllLocked,
  input  logic           ciStart,
  input  ciPkg::ciId_t   ciN,
  input  ciPkg::ciWord_t ciDataA,
  input  ciPkg::ciWord_t ciDataB,
  input  logic           stall,
  input  logic           busIdle,
  output logic           cpuReset,
  output logic           ciDone,
  output ciPkg::ciWord_t ciResult
);
  import ciPkg::*;
  import profilePkg::*;

  ciResponse_t   swapResponse;
  ciResponse_t   delayResponse;
  ciResponse_t   profileResponse;
  counterMask_t  enableMask;
  counterMask_t  clearMask;
  counterArray_t counters;

  resetSequencer resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .cpuReset(cpuReset)
  );

  // ############################
  // instruction request fan-out
  ciBus ciIf ();

  assign ciIf.start = ciStart;
  assign ciIf.n = ciN;
  assign ciIf.dataA = ciDataA;
  assign ciIf.dataB = ciDataB;

  swapByteUnit swapByte (
    .ci(ciIf.unit),
    .response(swapResponse)
  );

  delayUnit #(
    .cyclesPerMicrosecond(cpuCyclesPerMicrosecond)
  ) delayMicro (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ci(ciIf.unit),
    .response(delayResponse)
  );

  // ############################
  // profiler
  profileControl profileCtrl (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ci(ciIf.unit),
    .enableMask(enableMask),
    .clearMask(clearMask),
    .counters(counters),
    .response(profileResponse)
  );

  profileCounters profileCnt (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .cpuReset(cpuReset),
    .stall(stall),
    .busIdle(busIdle),
    .enableMask(enableMask),
    .clearMask(clearMask),
    .counters(counters)
  );

  // idle units drive zero, so OR merging is enough
  assign ciDone = swapResponse.done | delayResponse.done | profileResponse.done;
  assign ciResult = swapResponse.result | delayResponse.result | profileResponse.result;

  singleResponder : assert property (
    @(posedge s_systemClock) disable iff (!s_pllLocked)
    $onehot0({swapResponse.done, delayResponse.done, profileResponse.done})
  );

endmodule

// File: tests/tbOr1420CiSubsystem.sv
`timescale 1ns/1ps

module tbOr1420CiSubsystem;
  import ciPkg::*;
  import profilePkg::*;

  localparam int clockPeriod = 40;
  localparam int sampleDelay = 10;
  localparam int resetCycles = 10;
  localparam int swapCount = 8;
  localparam int eventCycles = 64;
  // worst case of every test in clock cycles plus margin
  localparam int watchdogCycles = (resetCycles + resetHoldCycles + 8) + (swapCount + 4)
    + ((0 + 1 + 3) * cpuCyclesPerMicrosecond + 3 * 8) + (52 + 8)
    + (2 * eventCycles + 20) + 200;

  logic    s_systemClock = 1'b0;
  logic    s_pllLocked;
  logic    ciStart;
  ciId_t   ciN;
  ciWord_t ciDataA;
  ciWord_t ciDataB;
  logic    stall;
  logic    busIdle;
  logic    cpuReset;
  logic    ciDone;
  ciWord_t ciResult;

  int     errorCount = 0;
  int     checkCount = 0;
  integer seed = 32'hb15d3498;

  or1420CiSubsystem UUT (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .stall(stall),
    .busIdle(busIdle),
    .cpuReset(cpuReset),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

  initial begin
    forever #(clockPeriod / 2) s_systemClock = ~s_systemClock;
  end

  initial begin
    #(watchdogCycles * clockPeriod);
    $display("watchdog expired before all tests finished");
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    $display("** FAIL **");
    $finish;
  end

  // ##############################
  // compare tasks and helpers

  task automatic checkBit(input string testName, input logic expected, input logic actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch %s: expected %b, actual %b", testName, expected, actual);
    end
  endtask

  task automatic checkWord(input string testName, input ciWord_t expected,
                           input ciWord_t actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("mismatch %s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  // byte i of the result comes from byte 3-i, or from byte i^1 in halfword mode
  function automatic ciWord_t swapExpected(input ciWord_t a, input logic halfMode);
    ciWord_t result;
    int      idx;
    result = '0;
    for (int i = 0; i < 4; i++) begin
      idx = halfMode ? (i ^ 1) : (3 - i);
      result[8 * i +: 8] = a[8 * idx +: 8];
    end
    return result;
  endfunction

  function automatic ciWord_t profileCmd(input counterMask_t en, input counterMask_t dis,
                                         input counterMask_t clr);
    ciWord_t cmd;
    cmd = '0;
    cmd[enableField +: nrOfCounters] = en;
    cmd[disableField +: nrOfCounters] = dis;
    cmd[clearField +: nrOfCounters] = clr;
    return cmd;
  endfunction

  // starts on a falling edge and returns on the falling edge after the start cycle
  task automatic issueInstr(input ciId_t n, input ciWord_t a, input ciWord_t b,
                            output logic done, output ciWord_t result);
    ciStart = 1'b1;
    ciN = n;
    ciDataA = a;
    ciDataB = b;
    #(sampleDelay);
    done = ciDone;
    result = ciResult;
    @(negedge s_systemClock);
    ciStart = 1'b0;
  endtask

  task automatic profileRead(input string testName, input counterSel_t sel,
                             input ciWord_t cmd, input ciWord_t expected);
    logic    done;
    ciWord_t value;
    issueInstr(profileId, ciWord_t'(sel), cmd, done, value);
    checkBit({testName, " done"}, 1'b1, done);
    checkWord({testName, " value"}, expected, value);
  endtask

  task automatic driveEvents(input int cycles, input counterMask_t counting,
                             inout int tally[nrOfCounters]);
    logic [31:0] rnd;
    for (int i = 0; i < cycles; i++) begin
      rnd = $random(seed);
      stall = rnd[0];
      busIdle = rnd[1];
      if (counting[1] && stall) tally[1]++;
      if (counting[2] && busIdle) tally[2]++;
      if (counting[3] && stall && busIdle) tally[3]++;
      @(negedge s_systemClock);
    end
    stall = 1'b0;
    busIdle = 1'b0;
  endtask

  // ##############################
  // tests

  task automatic testReset();
    repeat (resetCycles) begin
      @(negedge s_systemClock);
      checkBit("reset held", 1'b1, cpuReset);
      checkBit("reset done", 1'b0, ciDone);
    end
    s_pllLocked = 1'b1;
    for (int k = 1; k <= resetHoldCycles + 4; k++) begin
      @(negedge s_systemClock);
      checkBit("reset release", (k < resetHoldCycles) ? 1'b1 : 1'b0, cpuReset);
      checkBit("reset done", 1'b0, ciDone);
    end
  endtask

  task automatic testSwap();
    logic        done;
    ciWord_t     value;
    logic [31:0] rnd;
    for (int i = 0; i < swapCount; i++) begin
      rnd = $random(seed);
      issueInstr(swapByteId, rnd, ciWord_t'(i % 2), done, value);
      checkBit("swap done", 1'b1, done);
      checkWord("swap result", swapExpected(rnd, (i % 2) == 1), value);
    end
    // nobody answers an unused id
    issueInstr(8'd2, 32'h12345678, '0, done, value);
    checkBit("unused id done", 1'b0, done);
    checkWord("unused id result", '0, value);
    issueInstr(8'hff, 32'hcafe0001, 32'h1, done, value);
    checkBit("unused id done", 1'b0, done);
    checkWord("unused id result", '0, value);
  endtask

  task automatic delayRun(input ciWord_t micros);
    int expectedEdges;
    int edges;
    logic seen;
    expectedEdges = int'(micros) * cpuCyclesPerMicrosecond + 1;
    edges = 0;
    seen = 1'b0;
    ciStart = 1'b1;
    ciN = delayId;
    ciDataA = micros;
    ciDataB = '0;
    #(sampleDelay);
    checkBit("delay start cycle", 1'b0, ciDone);
    while (!seen && edges < expectedEdges + 10) begin
      @(negedge s_systemClock);
      ciStart = 1'b0;
      edges++;
      #(sampleDelay);
      seen = ciDone;
      if (seen) checkWord("delay result", '0, ciResult);
    end
    if (!seen) begin
      errorCount++;
      $display("delay of %0d us never signalled done", micros);
    end else begin
      checkWord("delay edges", ciWord_t'(expectedEdges), ciWord_t'(edges));
    end
    // done must be a single pulse
    repeat (3) begin
      @(negedge s_systemClock);
      #(sampleDelay);
      checkBit("delay extra done", 1'b0, ciDone);
    end
    @(negedge s_systemClock);
  endtask

  task automatic testCycleCount();
    logic        done;
    ciWord_t     value;
    logic [31:0] rnd;
    int          k;
    rnd = $random(seed);
    k = int'(rnd[4:0]) + 20;
    issueInstr(profileId, '0, profileCmd(4'b0001, '0, '0), done, value);
    checkBit("cycle enable done", 1'b1, done);
    repeat (k) @(negedge s_systemClock);
    profileRead("cycle count", 2'd0, '0, ciWord_t'(k));
    // the clear command still returns the value before it
    profileRead("cycle clear", 2'd0, profileCmd('0, '0, 4'b0001), ciWord_t'(k + 1));
    profileRead("cycle after clear", 2'd0, '0, '0);
    issueInstr(profileId, '0, profileCmd('0, 4'b0001, '0), done, value);
  endtask

  task automatic testEvents();
    logic    done;
    ciWord_t value;
    int      tally[nrOfCounters];
    ciWord_t held;
    tally = '{default: 0};
    issueInstr(profileId, '0, profileCmd(4'b1110, '0, '0), done, value);
    checkBit("event enable done", 1'b1, done);
    driveEvents(eventCycles, 4'b1110, tally);
    profileRead("stall count", 2'd1, '0, ciWord_t'(tally[1]));
    profileRead("idle count", 2'd2, '0, ciWord_t'(tally[2]));
    profileRead("stall idle count", 2'd3, '0, ciWord_t'(tally[3]));
    held = ciWord_t'(tally[2]);
    // counter 2 off while the others keep counting
    issueInstr(profileId, '0, profileCmd('0, 4'b0100, '0), done, value);
    driveEvents(eventCycles, 4'b1010, tally);
    profileRead("stall count", 2'd1, '0, ciWord_t'(tally[1]));
    profileRead("idle held", 2'd2, '0, held);
    profileRead("stall idle count", 2'd3, '0, ciWord_t'(tally[3]));
  endtask

  // ##############################
  initial begin
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    stall = 1'b0;
    busIdle = 1'b0;

    testReset();
    testSwap();
    delayRun(32'd0);
    delayRun(32'd1);
    delayRun(32'd3);
    testCycleCount();
    testEvents();

    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: all.f
hw/ciPkg.sv
hw/profilePkg.sv
hw/ciBus.sv
hw/resetSequencer.sv
hw/swapByteUnit.sv
hw/delayUnit.sv
hw/profileControl.sv
hw/profileCounters.sv
hw/or1420CiSubsystem.sv
tests/tbOr1420CiSubsystem.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f \
  --top-module tbOr1420CiSubsystem -Mdir obj_dir -o simTb
if [ $? -ne 0 ]; then
  echo "compilation failed"
  exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "** FAIL **" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

exit 0
